/* verif/lsu_trace.txt */
// op base imm sdata | found pfn valid dirty | tlbw flush | exc code paddr size strb wdata unc
// all hex, one access per line, a lone ffffffff ends the trace
7 80001000 0000 11223344 0 00000 0 0 0 0 0 00 00001000 0 1 44444444 0
7 80001000 0003 11223344 0 00000 0 0 0 0 0 00 00001003 0 8 44444444 0
8 80001000 0000 11223344 0 00000 0 0 0 0 0 00 00001000 1 3 33443344 0
8 80001000 0002 11223344 0 00000 0 0 0 0 0 00 00001002 1 c 33443344 0
9 80001000 0000 11223344 0 00000 0 0 0 0 0 00 00001000 2 f 11223344 0
a 80001000 0000 11223344 0 00000 0 0 0 0 0 00 00001000 0 1 00000011 0
a 80001000 0001 11223344 0 00000 0 0 0 0 0 00 00001000 1 3 00001122 0
a 80001000 0002 11223344 0 00000 0 0 0 0 0 00 00001000 2 7 00112233 0
a 80001000 0003 11223344 0 00000 0 0 0 0 0 00 00001000 2 f 11223344 0
b 80001000 0000 11223344 0 00000 0 0 0 0 0 00 00001000 2 f 11223344 0
b 80001000 0001 11223344 0 00000 0 0 0 0 0 00 00001001 2 e 22334400 0
b 80001000 0002 11223344 0 00000 0 0 0 0 0 00 00001002 1 c 33440000 0
b 80001000 0003 11223344 0 00000 0 0 0 0 0 00 00001003 0 8 44000000 0
0 a0002000 0003 00000000 0 00000 0 0 0 0 0 00 00002003 0 0 00000000 1
3 a0002000 0002 00000000 0 00000 0 0 0 0 0 00 00002002 1 0 00000000 1
4 a0002000 0004 00000000 0 00000 0 0 0 0 0 00 00002004 2 0 00000000 1
5 a0002000 0001 00000000 0 00000 0 0 0 0 0 00 00002001 1 0 00000000 1
6 a0002000 0003 00000000 0 00000 0 0 0 0 0 00 00002003 0 0 00000000 1
2 80003000 0001 00000000 0 00000 0 0 0 0 1 04 00000000 0 0 00000000 0
4 80003000 0002 00000000 0 00000 0 0 0 0 1 04 00000000 0 0 00000000 0
8 a0003000 0003 12345678 0 00000 0 0 0 0 1 05 00000000 0 0 00000000 0
9 00400000 0002 12345678 1 12345 1 1 0 0 1 05 00000000 0 0 00000000 0
9 00400000 0010 cafef00d 1 12345 1 1 0 0 0 00 12345010 2 f cafef00d 0
4 00400000 0020 00000000 1 54321 1 1 0 0 0 00 12345020 2 0 00000000 0
4 00400000 0024 00000000 1 54321 1 1 1 0 0 00 54321024 2 0 00000000 0
4 00400000 1008 00000000 1 0beef 1 1 0 0 0 00 0beef008 2 0 00000000 0
4 00402010 fff0 00000000 1 0cafe 1 1 0 0 0 00 0cafe000 2 0 00000000 0
4 00800000 0000 00000000 0 00000 0 0 0 0 1 02 00000000 0 0 00000000 0
9 00800000 0004 00000001 1 00000 0 1 1 0 1 03 00000000 0 0 00000000 0
9 00800000 0008 00000001 1 0f00d 1 0 1 0 1 01 00000000 0 0 00000000 0
4 00800000 000c 00000000 1 0dead 1 1 0 0 0 00 0f00d00c 2 0 00000000 0
9 80004000 0000 55aa55aa 0 00000 0 0 0 1 0 00 00000000 0 0 00000000 0
7 80004000 0001 000000ab 0 00000 0 0 0 0 0 00 00004001 0 2 abababab 0
ffffffff

/* list.f */
+incdir+design
design/lsu_pkg.sv
design/tlb_pkg.sv
design/store_align.sv
design/tlb_refill_fsm.sv
design/lsu_stage.sv
verif/lsu_checker.sv
verif/tb_lsu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lsu -f list.f -o sim_lsu

# keep running past assertion errors so the testbench prints its verdict
./obj_dir/sim_lsu +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0

/* verif/tb_lsu.sv */
`default_nettype none

module tb_lsu
    import lsu_pkg::*, tlb_pkg::*;
();

    localparam int NCOL      = 17;   // words per trace line
    localparam int MAX_TESTS = 64;
    localparam int TIMEOUT   = 50;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic        in_ready;
    mem_req_t    in_req;
    logic        out_valid;
    logic        out_ready;
    lsu_result_t out_result;
    logic        cache_valid;
    logic        cache_ready;
    cache_req_t  cache_req;
    tlb_query_t  tlb_query;
    tlb_reply_t  tlb_reply;
    logic [7:0]  entryhi_asid;
    logic        tlb_write;
    logic        flush;

    logic [31:0] trace_mem [0:MAX_TESTS*NCOL-1];
    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        timed_out;

    lsu_stage dut_i (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_req       (in_req),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_result   (out_result),
        .cache_valid  (cache_valid),
        .cache_ready  (cache_ready),
        .cache_req    (cache_req),
        .tlb_query    (tlb_query),
        .tlb_reply    (tlb_reply),
        .entryhi_asid (entryhi_asid),
        .tlb_write    (tlb_write),
        .flush        (flush)
    );

    bind lsu_stage lsu_checker checker_i (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_result  (out_result),
        .cache_valid (cache_valid),
        .cache_ready (cache_ready),
        .cache_req   (cache_req)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic run_access(input int idx);
        logic [31:0] row [NCOL];
        mem_req_t    req;
        tlb_reply_t  rep;
        logic [31:0] ea;
        int          imm_s;
        logic        is_store;
        logic        accepted;
        logic        done;
        logic        cache_seen;
        logic        fired;
        cache_req_t  got_req;
        lsu_result_t got_res;
        tlb_query_t  got_qry;
        int          d_out;
        int          d_cache;
        int          cycles;
        int          errs_before;
        for (int c = 0; c < NCOL; c++) begin
            row[c] = trace_mem[idx*NCOL+c];
        end
        errs_before    = errors;
        req.op         = mem_op_t'(row[0][3:0]);
        req.base       = row[1];
        req.imm        = row[2][15:0];
        req.store_data = row[3];
        rep.found      = row[4][0];
        rep.pfn        = row[5][19:0];
        rep.valid      = row[6][0];
        rep.dirty      = row[7][0];
        imm_s    = $signed(row[2][15:0]);
        ea       = row[1] + imm_s;
        is_store = req.op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
        if (row[8][0]) begin   // invalidate the cached mapping first
            @(posedge clk);
            tlb_write <= 1'b1;
            @(posedge clk);
            tlb_write <= 1'b0;
        end
        @(posedge clk);
        in_req    <= req;
        tlb_reply <= rep;
        in_valid  <= 1'b1;
        accepted = 1'b0;
        cycles   = 0;
        while (!accepted && cycles < TIMEOUT) begin
            @(negedge clk);
            accepted = in_ready;
            cycles++;
        end
        if (!accepted) begin
            $display("timeout: in_ready stayed low for access %0d", idx);
            timed_out = 1'b1;
            return;
        end
        @(posedge clk);
        in_valid <= 1'b0;
        d_out   = $urandom % 4;
        d_cache = $urandom % 4;
        fired   = 1'b0;
        if (row[9][0]) begin
            // stall the access, then flush it
            repeat (2) @(posedge clk);
            flush <= 1'b1;
            @(posedge clk);
            flush       <= 1'b0;
            out_ready   <= 1'b1;
            cache_ready <= 1'b1;
            repeat (4) begin
                @(negedge clk);
                if (out_valid || cache_valid) fired = 1'b1;
            end
            check("activity after flush", 32'(fired), 32'd0);
            check("in_ready after flush", 32'(in_ready), 32'd1);
        end else begin
            done       = 1'b0;
            cache_seen = 1'b0;
            cycles     = 0;
            while (!done && cycles < TIMEOUT) begin
                @(posedge clk);
                out_ready   <= (cycles >= d_out);
                cache_ready <= (cycles >= d_cache);
                @(negedge clk);
                if (cycles == 0) got_qry = tlb_query;   // slot holds the access
                if (cache_valid) cache_seen = 1'b1;
                if (cache_valid && cache_ready) begin
                    fired   = 1'b1;
                    got_req = cache_req;
                end
                if (out_valid && out_ready) begin
                    done    = 1'b1;
                    got_res = out_result;
                end
                cycles++;
            end
            if (!done) begin
                $display("timeout: access %0d never produced a result", idx);
                timed_out = 1'b1;
                return;
            end
            // vpn2 | odd page | asid
            check("tlb_query", 32'(got_qry), {4'h0, ea[31:12], entryhi_asid});
            check("has_exc", 32'(got_res.has_exc), 32'(row[10][0]));
            check("addr_low", 32'(got_res.addr_low), 32'(ea[1:0]));
            if (row[10][0]) begin
                check("exc_code", 32'(got_res.exc_code), 32'(row[11][4:0]));
                check("badvaddr", got_res.badvaddr, ea);
                check("cache request on exception", 32'(cache_seen), 32'd0);
            end else begin
                check("cache handshake", 32'(fired), 32'd1);
                check("paddr", got_req.paddr, row[12]);
                check("size", 32'(got_req.size), 32'(row[13][1:0]));
                check("wstrb", 32'(got_req.wstrb), 32'(row[14][3:0]));
                check("uncached", 32'(got_req.uncached), 32'(row[16][0]));
                check("is_store", 32'(got_req.is_store), 32'(is_store));
                if (is_store) check("wdata", got_req.wdata, row[15]);
            end
        end
        @(posedge clk);
        out_ready   <= 1'b0;
        cache_ready <= 1'b0;
        tests_run++;
        if (errors != errs_before) tests_failed++;
        $display("test %0d op %h: %s", idx, row[0][3:0],
                 (errors == errs_before) ? "ok" : "mismatch");
    endtask

    initial begin
        int n;
        void'($urandom(32'h55da));
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        n            = 0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_req       = '0;
        out_ready    = 1'b0;
        cache_ready  = 1'b0;
        tlb_reply    = '0;
        entryhi_asid = 8'h05;
        tlb_write    = 1'b0;
        flush        = 1'b0;
        $readmemh("verif/lsu_trace.txt", trace_mem);
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        while (n < MAX_TESTS && trace_mem[n*NCOL] !== 32'hffff_ffff && !timed_out) begin
            run_access(n);
            n++;
        end
        if (tests_run == 0) $display("no accesses were read from the trace file");
        $display("tests run %0d, failed %0d, mismatches %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, dut_i.checker_i.fail_count);
        if (errors == 0 && tests_failed == 0 && !timed_out && tests_run > 0 &&
            dut_i.checker_i.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/lsu_checker.sv */
`default_nettype none

module lsu_checker
    import lsu_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        flush,
    input logic        in_ready,
    input logic        out_valid,
    input logic        out_ready,
    input lsu_result_t out_result,
    input logic        cache_valid,
    input logic        cache_ready,
    input cache_req_t  cache_req
);

    int fail_count = 0;   // read by the testbench at the end

    // request held until the cache takes it
    hold_cache_req: assert property (@(posedge clk) disable iff (reset)
        cache_valid && !cache_ready && !flush |=>
            flush || !out_ready || (cache_valid && $stable(cache_req)))
        else begin
            $error("cache request changed before cache_ready");
            fail_count++;
        end

    hold_result: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready && !flush |=> flush || (out_valid && $stable(out_result)))
        else begin
            $error("result changed while out_ready was low");
            fail_count++;
        end

    // faulting accesses never reach the cache
    no_cache_on_exc: assert property (@(posedge clk) disable iff (reset)
        out_valid && out_result.has_exc |-> !cache_valid)
        else begin
            $error("cache request raised for an access with an exception");
            fail_count++;
        end

    cache_needs_out_ready: assert property (@(posedge clk) disable iff (reset)
        cache_valid |-> out_ready)
        else begin
            $error("cache request raised while out_ready was low");
            fail_count++;
        end

    flush_empties: assert property (@(posedge clk) disable iff (reset)
        flush |=> in_ready && !out_valid && !cache_valid)
        else begin
            $error("slot not empty one cycle after flush");
            fail_count++;
        end

endmodule

`default_nettype wire

/* design/lsu_stage.sv */
`default_nettype none

`include "lsu_params.svh"

module lsu_stage
    import lsu_pkg::*, tlb_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  mem_req_t               in_req,
    output logic                   out_valid,
    input  logic                   out_ready,
    output lsu_result_t            out_result,
    output logic                   cache_valid,
    input  logic                   cache_ready,
    output cache_req_t             cache_req,
    output tlb_query_t             tlb_query,
    input  tlb_reply_t             tlb_reply,
    input  logic [`LSU_ASID_W-1:0] entryhi_asid,
    input  logic                   tlb_write,
    input  logic                   flush
);

    logic                   slot_valid;
    mem_req_t               slot_req;
    logic [`LSU_ADDR_W-1:0] ea;
    vaddr_u                 va_acc;
    logic                   mapped;
    logic                   uncached;
    logic                   is_store;
    logic [3:0]             wstrb;
    logic [1:0]             size;
    logic [`LSU_ADDR_W-1:0] wdata;
    logic                   addr_err;
    logic [4:0]             align_exc;
    logic                   fsm_ready;
    logic                   tlb_fault;
    logic                   tlb_mod;
    logic [`LSU_PFN_W-1:0]  pfn;
    logic                   trans_ok;
    logic                   tlb_exc;
    logic                   exc_now;
    logic                   leave;
    logic [4:0]             exc_code;

    always_ff @(posedge clk) begin
        if (reset) begin
            slot_valid <= 1'b0;
        end else if (flush) begin
            slot_valid <= 1'b0;
        end else if (in_ready) begin
            slot_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            slot_req <= in_req;
        end
    end

    assign ea       = slot_req.base + {{16{slot_req.imm[15]}}, slot_req.imm};
    assign va_acc   = (slot_req.op == OP_SWL) ? {ea[31:2], 2'b00} : ea;   // swl goes out word aligned
    assign mapped   = va_acc.seg.region[2:1] != `LSU_SEG_UNMAPPED;
    assign uncached = va_acc.seg.region == `LSU_SEG_KSEG1;
    assign is_store = is_store_op(slot_req.op);

    store_align u_align (
        .op         (slot_req.op),
        .addr_low   (ea[1:0]),
        .store_data (slot_req.store_data),
        .wstrb      (wstrb),
        .size       (size),
        .wdata      (wdata),
        .addr_error (addr_err),
        .exc_code   (align_exc)
    );

    tlb_refill_fsm u_tlb_fsm (
        .clk             (clk),
        .reset           (reset),
        .start           (slot_valid && mapped && !addr_err),
        .vaddr           (va_acc),
        .asid            (entryhi_asid),
        .is_store        (is_store),
        .tlb_query       (tlb_query),
        .tlb_reply       (tlb_reply),
        .tlb_write       (tlb_write),
        .issue_ok        (leave),
        .pfn             (pfn),
        .ready           (fsm_ready),
        .fault           (tlb_fault),
        .fault_store_mod (tlb_mod)
    );

    assign trans_ok = !mapped || fsm_ready;
    assign tlb_exc  = mapped && (tlb_fault || tlb_mod);
    assign exc_now  = slot_valid && (addr_err || tlb_exc);

    // address error wins over any TLB fault
    assign exc_code = addr_err  ? align_exc :
                      tlb_mod   ? EXC_MOD   :
                      tlb_fault ? (is_store ? EXC_TLBS : EXC_TLBL) : EXC_NONE;

    // issue only when the next stage can take the result
    assign cache_valid = slot_valid && !flush && out_ready && !addr_err && trans_ok && !tlb_exc;
    assign out_valid   = slot_valid && !flush && (exc_now || (cache_valid && cache_ready));
    assign leave       = out_valid && out_ready;
    assign in_ready    = !slot_valid || leave;

    assign cache_req.is_store = is_store;
    assign cache_req.uncached = uncached;
    assign cache_req.paddr    = mapped ? {pfn, va_acc.mapped.page_off}
                                       : {{`LSU_SEG_W{1'b0}}, va_acc.seg.offset};
    assign cache_req.size     = size;
    assign cache_req.wstrb    = wstrb;
    assign cache_req.wdata    = wdata;

    assign out_result.has_exc  = exc_now;
    assign out_result.exc_code = exc_code;
    assign out_result.badvaddr = ea;
    assign out_result.addr_low = ea[1:0];

endmodule

`default_nettype wire

/* design/tlb_refill_fsm.sv */
`default_nettype none

`include "lsu_params.svh"

module tlb_refill_fsm
    import tlb_pkg::*;
(
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  vaddr_u                 vaddr,
    input  logic [`LSU_ASID_W-1:0] asid,
    input  logic                   is_store,
    output tlb_query_t             tlb_query,
    input  tlb_reply_t             tlb_reply,
    input  logic                   tlb_write,
    input  logic                   issue_ok,
    output logic [`LSU_PFN_W-1:0]  pfn,
    output logic                   ready,
    output logic                   fault,
    output logic                   fault_store_mod
);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        ISSUE
    } state_t;

    state_t state;
    state_t state_next;

    // one-entry cached mapping
    logic [`LSU_VPN2_W-1:0] map_vpn2;
    logic                   map_odd;
    logic                   map_found;
    logic [`LSU_PFN_W-1:0]  map_pfn;
    logic                   map_valid;
    logic                   map_dirty;
    logic                   map_entry_valid;
    logic                   hit;
    logic                   capture;

    assign hit = map_entry_valid &&
                 map_vpn2 == vaddr.mapped.vpn2 &&
                 map_odd == vaddr.mapped.odd;

    // search port is combinational, query always follows the slot
    assign tlb_query.vpn2 = vaddr.mapped.vpn2;
    assign tlb_query.odd  = vaddr.mapped.odd;
    assign tlb_query.asid = asid;

    // a flushed slot drops start, so nothing stale gets cached
    assign capture = (state == LOOKUP) && start;

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (start && !hit) state_next = LOOKUP;
            LOOKUP:  state_next = start ? ISSUE : IDLE;
            ISSUE:   if (!start || issue_ok) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            map_entry_valid <= 1'b0;
        end else if (tlb_write) begin
            map_entry_valid <= 1'b0;   // TLB contents changed
        end else if (capture) begin
            map_entry_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            map_vpn2  <= vaddr.mapped.vpn2;
            map_odd   <= vaddr.mapped.odd;
            map_found <= tlb_reply.found;
            map_pfn   <= tlb_reply.pfn;
            map_valid <= tlb_reply.valid;
            map_dirty <= tlb_reply.dirty;
        end
    end

    assign ready = start && ((state == IDLE && hit) || state == ISSUE);
    assign pfn   = map_pfn;

    // refill or invalid entry
    assign fault           = ready && (!map_found || !map_valid);
    assign fault_store_mod = ready && is_store && map_found && map_valid && !map_dirty;

endmodule

`default_nettype wire

/* design/store_align.sv */
`default_nettype none

module store_align
    import lsu_pkg::*;
(
    input  mem_op_t     op,
    input  logic [1:0]  addr_low,
    input  logic [31:0] store_data,
    output logic [3:0]  wstrb,
    output logic [1:0]  size,
    output logic [31:0] wdata,
    output logic        addr_error,
    output logic [4:0]  exc_code
);

    logic [1:0] left_size;
    logic [1:0] right_size;

    // lwl/swl cover bytes 0..off, lwr/swr cover off..3
    assign left_size  = (addr_low == 2'd3) ? 2'd2 : addr_low;
    assign right_size = (addr_low == 2'd0) ? 2'd2 : ~addr_low;

    always_comb begin
        wstrb      = 4'b0000;    // loads never write
        size       = 2'd2;
        wdata      = '0;
        addr_error = 1'b0;
        case (op)
            OP_LB, OP_LBU: size = 2'd0;
            OP_LH, OP_LHU: begin
                size       = 2'd1;
                addr_error = addr_low[0];
            end
            OP_LW:  addr_error = |addr_low;
            OP_LWL: size = left_size;
            OP_LWR: size = right_size;
            OP_SB: begin
                size  = 2'd0;
                wstrb = 4'b0001 << addr_low;
                wdata = {4{store_data[7:0]}};
            end
            OP_SH: begin
                size       = 2'd1;
                wstrb      = addr_low[1] ? 4'b1100 : 4'b0011;
                wdata      = {2{store_data[15:0]}};
                addr_error = addr_low[0];
            end
            OP_SW: begin
                wstrb      = 4'b1111;
                wdata      = store_data;
                addr_error = |addr_low;
            end
            OP_SWL: begin
                // upper bytes of rt land in the low lanes
                size  = left_size;
                wstrb = 4'b1111 >> ~addr_low;
                wdata = store_data >> {~addr_low, 3'b000};
            end
            OP_SWR: begin
                size  = right_size;
                wstrb = 4'b1111 << addr_low;
                wdata = store_data << {addr_low, 3'b000};
            end
            default: ;
        endcase
    end

    assign exc_code = !addr_error     ? EXC_NONE :
                      is_store_op(op) ? EXC_ADES : EXC_ADEL;

endmodule

`default_nettype wire

/* design/tlb_pkg.sv */
`default_nettype none

`include "lsu_params.svh"

package tlb_pkg;

    // mapped view, vpn2 | odd page | offset
    typedef struct packed {
        logic [`LSU_VPN2_W-1:0]     vpn2;
        logic                       odd;
        logic [`LSU_PAGE_OFF_W-1:0] page_off;
    } vaddr_map_t;

    // segment view for kseg decode
    typedef struct packed {
        logic [`LSU_SEG_W-1:0]     region;
        logic [`LSU_SEG_OFF_W-1:0] offset;
    } vaddr_seg_t;

    typedef union packed {
        vaddr_map_t mapped;
        vaddr_seg_t seg;
    } vaddr_u;

    typedef struct packed {
        logic [`LSU_VPN2_W-1:0] vpn2;
        logic                   odd;
        logic [`LSU_ASID_W-1:0] asid;
    } tlb_query_t;

    typedef struct packed {
        logic                  found;
        logic [`LSU_PFN_W-1:0] pfn;
        logic                  valid;
        logic                  dirty;
    } tlb_reply_t;

endpackage

`default_nettype wire

/* design/lsu_pkg.sv */
`default_nettype none

`include "lsu_params.svh"

package lsu_pkg;

    typedef enum logic [3:0] {
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_LWL,
        OP_LWR,
        OP_SB,
        OP_SH,
        OP_SW,
        OP_SWL,
        OP_SWR
    } mem_op_t;

    typedef struct packed {
        mem_op_t                op;
        logic [`LSU_ADDR_W-1:0] base;         // rs value
        logic [15:0]            imm;
        logic [`LSU_ADDR_W-1:0] store_data;   // rt value
    } mem_req_t;

    typedef struct packed {
        logic                   is_store;
        logic                   uncached;
        logic [`LSU_ADDR_W-1:0] paddr;
        logic [1:0]             size;
        logic [3:0]             wstrb;
        logic [`LSU_ADDR_W-1:0] wdata;
    } cache_req_t;

    typedef struct packed {
        logic                   has_exc;
        logic [4:0]             exc_code;
        logic [`LSU_ADDR_W-1:0] badvaddr;
        logic [1:0]             addr_low;     // byte offset for the load merge
    } lsu_result_t;

    localparam logic [4:0] EXC_NONE = 5'd0;
    localparam logic [4:0] EXC_MOD  = 5'd1;
    localparam logic [4:0] EXC_TLBL = 5'd2;
    localparam logic [4:0] EXC_TLBS = 5'd3;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;

    function automatic logic is_store_op(mem_op_t op);
        return op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};
    endfunction

endpackage

`default_nettype wire

/* design/lsu_params.svh */
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// address and translation widths
`define LSU_ADDR_W      32
`define LSU_PFN_W       20
`define LSU_VPN2_W      19
`define LSU_ASID_W      8
`define LSU_PAGE_OFF_W  12

// segment view of a virtual address
`define LSU_SEG_W       3
`define LSU_SEG_OFF_W   29

// top two segment bits of kseg0/kseg1, the unmapped window
`define LSU_SEG_UNMAPPED  2'b10
// kseg1 is unmapped and uncached
`define LSU_SEG_KSEG1     3'b101

`endif
